//--- Makefile
SIM    := verilator
FLAGS  := --binary --timing --assert -Wno-fatal
TOP    := tb_fetch_unit
FLIST  := vlog.f
OBJDIR := obj_dir
BIN    := $(OBJDIR)/V$(TOP)
SRCS   := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "ALL TESTS PASSED"

clean:
	rm -rf $(OBJDIR)

//--- hdl/btb.sv
// direct-mapped branch target buffer with combinational lookup and training
`timescale 1ns/10ps

module btb
  import fetch_cfg_pkg::*;
(
  input  logic         i_clk,
  input  logic         i_reset_n,
  btb_update_if.tbl    upd,
  input  addr_t        i_lookup_pc,
  output logic         o_hit,
  output addr_t        o_target
);

  typedef logic [BTB_IDX_W-1:0] idx_t;
  typedef logic [BTB_TAG_W-1:0] tag_t;

  logic [BTB_ENTRIES-1:0] r_valid;
  tag_t                   r_tag    [BTB_ENTRIES];
  addr_t                  r_target [BTB_ENTRIES];

  idx_t w_lookup_idx;
  tag_t w_lookup_tag;
  idx_t w_upd_idx;
  tag_t w_upd_tag;
  logic w_upd_write;
  logic w_upd_clear;

  // ==========================================================================
  // lookup
  // ==========================================================================
  assign w_lookup_idx = i_lookup_pc[2 +: BTB_IDX_W];        // word offset skipped
  assign w_lookup_tag = i_lookup_pc[XLEN-1 -: BTB_TAG_W];

  assign o_hit    = r_valid[w_lookup_idx] & (r_tag[w_lookup_idx] == w_lookup_tag);
  assign o_target = r_target[w_lookup_idx];

  // ==========================================================================
  // training
  // ==========================================================================
  assign w_upd_idx = upd.pc[2 +: BTB_IDX_W];
  assign w_upd_tag = upd.pc[XLEN-1 -: BTB_TAG_W];

  assign w_upd_write = upd.valid & upd.taken;
  // not-taken only evicts its own entry, never an aliased one
  assign w_upd_clear = upd.valid & ~upd.taken & r_valid[w_upd_idx] &
                       (r_tag[w_upd_idx] == w_upd_tag);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
    end else if (w_upd_write) begin
      r_valid[w_upd_idx] <= 1'b1;
    end else if (w_upd_clear) begin
      r_valid[w_upd_idx] <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_upd_write) begin
      r_tag[w_upd_idx]    <= w_upd_tag;
      r_target[w_upd_idx] <= upd.target;
    end
  end

endmodule

//--- hdl/btb_update_if.sv
// branch training channel from resolved branches into the btb
`timescale 1ns/10ps

interface btb_update_if #(
  parameter int ADDR_W = 32
);

  logic              valid;   // one-cycle pulse per resolved branch
  logic [ADDR_W-1:0] pc;      // pc of the branch itself
  logic [ADDR_W-1:0] target;
  logic              taken;

  // resolved-branch side
  modport trainer (output valid, pc, target, taken);

  // btb storage side
  modport tbl (input valid, pc, target, taken);

endinterface

//--- hdl/fetch_cfg_pkg.sv
// fetch unit configuration: datapath widths, btb geometry and reset pc
package fetch_cfg_pkg;

  // ==========================================================================
  // datapath
  // ==========================================================================
  localparam int XLEN       = 32;
  localparam int INST_BYTES = 4;    // one rv32 instruction per fetch

  typedef logic [XLEN-1:0] addr_t;
  typedef logic [XLEN-1:0] inst_t;

  // first fetch address out of reset
  localparam addr_t RESET_PC = 32'h0000_1000;

  // ==========================================================================
  // branch target buffer
  // ==========================================================================
  localparam int BTB_ENTRIES = 16;
  localparam int BTB_IDX_W   = $clog2(BTB_ENTRIES);

  // pc bits above the index, byte offset of the word excluded
  localparam int BTB_TAG_W   = XLEN - BTB_IDX_W - 2;

endpackage

//--- hdl/fetch_sequencer.sv
// fetch pc sequencing, wishbone classic read master and decode output register
`timescale 1ns/10ps

module fetch_sequencer
  import fetch_cfg_pkg::*;
(
  input  logic  i_clk,
  input  logic  i_reset_n,
  input  logic  i_redirect,
  input  addr_t i_redirect_pc,
  output addr_t o_lookup_pc,
  input  logic  i_btb_hit,
  input  addr_t i_btb_target,
  output logic  o_wb_cyc,
  output logic  o_wb_stb,
  output addr_t o_wb_adr,
  input  inst_t i_wb_dat,
  input  logic  i_wb_ack,
  output logic  o_inst_valid,
  output addr_t o_inst_pc,
  output inst_t o_inst_data,
  input  logic  i_inst_ready
);

  typedef enum logic {
    IDLE = 1'b0,
    BUS  = 1'b1
  } fetch_state_t;

  fetch_state_t r_state;
  fetch_state_t w_state_next;
  addr_t        r_pc;
  addr_t        w_pc_next;
  logic         r_redir_pend;     // redirect seen while the bus was busy
  addr_t        r_redir_pc;
  logic         r_out_valid;
  addr_t        r_out_pc;
  inst_t        r_out_data;
  logic         w_out_free;
  logic         w_ack;
  logic         w_ack_keep;

  // output register empty, or emptied on this edge
  assign w_out_free = ~r_out_valid | i_inst_ready | i_redirect;
  assign w_ack      = (r_state == BUS) & i_wb_ack;
  assign w_ack_keep = w_ack & ~r_redir_pend & ~i_redirect;   // data not discarded

  // ==========================================================================
  // next state and next pc
  // ==========================================================================
  always_comb begin
    w_state_next = r_state;
    w_pc_next    = r_pc;
    case (r_state)
      IDLE : begin
        if (i_redirect) begin
          w_pc_next = i_redirect_pc;
        end
        if (w_out_free) begin
          w_state_next = BUS;
        end
      end
      BUS : begin
        if (i_wb_ack) begin
          w_state_next = IDLE;                      // cyc drops on the next edge
          if (i_redirect) begin
            w_pc_next = i_redirect_pc;
          end else if (r_redir_pend) begin
            w_pc_next = r_redir_pc;
          end else if (i_btb_hit) begin
            w_pc_next = i_btb_target;
          end else begin
            w_pc_next = r_pc + addr_t'(INST_BYTES);
          end
        end
      end
      default : w_state_next = IDLE;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state      <= IDLE;
      r_pc         <= RESET_PC;
      r_redir_pend <= 1'b0;
      r_out_valid  <= 1'b0;
    end else begin
      r_state <= w_state_next;
      r_pc    <= w_pc_next;
      if (w_ack) begin
        r_redir_pend <= 1'b0;
      end else if ((r_state == BUS) & i_redirect) begin
        r_redir_pend <= 1'b1;
      end
      if (i_redirect) begin
        r_out_valid <= 1'b0;
      end else if (w_ack_keep) begin
        r_out_valid <= 1'b1;
      end else if (i_inst_ready) begin
        r_out_valid <= 1'b0;
      end
    end
  end

  // payload, only meaningful under its valid flag
  always_ff @(posedge i_clk) begin
    if ((r_state == BUS) & i_redirect & ~i_wb_ack) begin
      r_redir_pc <= i_redirect_pc;                // newer redirect overwrites
    end
    if (w_ack_keep) begin
      r_out_pc   <= r_pc;
      r_out_data <= i_wb_dat;
    end
  end

  // ==========================================================================
  // outputs
  // ==========================================================================
  assign o_lookup_pc  = r_pc;
  assign o_wb_cyc     = (r_state == BUS);
  assign o_wb_stb     = (r_state == BUS);
  assign o_wb_adr     = r_pc;              // pc only moves on the ack edge
  assign o_inst_valid = r_out_valid;
  assign o_inst_pc    = r_out_pc;
  assign o_inst_data  = r_out_data;

endmodule

//--- hdl/fetch_unit.sv
// instruction fetch front end top: trap targets, btb and fetch sequencer
`timescale 1ns/10ps

module fetch_unit
  import fetch_cfg_pkg::*;
  import trap_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_reset_n,
  // commit flush and csr state
  input  logic        i_cmt_valid,
  input  flush_kind_t i_cmt_kind,
  input  cause_t      i_cmt_cause,
  input  addr_t       i_cmt_epc,
  input  addr_t       i_mtvec,
  input  addr_t       i_stvec,
  input  addr_t       i_mepc,
  input  addr_t       i_sepc,
  input  logic [15:0] i_medeleg,
  // resolved branch
  input  logic        i_br_upd_valid,
  input  addr_t       i_br_upd_pc,
  input  addr_t       i_br_upd_target,    // correct next pc of the branch
  input  logic        i_br_upd_taken,
  input  logic        i_br_upd_mispredict,
  // wishbone instruction bus
  output logic        o_wb_cyc,
  output logic        o_wb_stb,
  output addr_t       o_wb_adr,
  output logic        o_wb_we,
  input  inst_t       i_wb_dat,
  input  logic        i_wb_ack,
  // decode
  output logic        o_inst_valid,
  output addr_t       o_inst_pc,
  output inst_t       o_inst_data,
  input  logic        i_inst_ready
);

  logic  w_br_mispredict;
  logic  w_redirect;
  addr_t w_redirect_pc;
  addr_t w_lookup_pc;
  logic  w_btb_hit;
  addr_t w_btb_target;

  btb_update_if #(.ADDR_W(XLEN)) w_btb_upd_if ();

  assign w_btb_upd_if.valid  = i_br_upd_valid;
  assign w_btb_upd_if.pc     = i_br_upd_pc;
  assign w_btb_upd_if.target = i_br_upd_target;
  assign w_btb_upd_if.taken  = i_br_upd_taken;

  assign w_br_mispredict = i_br_upd_valid & i_br_upd_mispredict;
  assign o_wb_we         = 1'b0;                         // read-only master

  trap_target_calc trap_target_calc_i (
    .i_cmt_valid     (i_cmt_valid),
    .i_cmt_kind      (i_cmt_kind),
    .i_cmt_cause     (i_cmt_cause),
    .i_cmt_epc       (i_cmt_epc),
    .i_mtvec         (i_mtvec),
    .i_stvec         (i_stvec),
    .i_mepc          (i_mepc),
    .i_sepc          (i_sepc),
    .i_medeleg       (i_medeleg),
    .i_br_mispredict (w_br_mispredict),
    .i_br_target     (i_br_upd_target),
    .o_redirect      (w_redirect),
    .o_redirect_pc   (w_redirect_pc)
  );

  btb btb_i (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .upd         (w_btb_upd_if.tbl),
    .i_lookup_pc (w_lookup_pc),
    .o_hit       (w_btb_hit),
    .o_target    (w_btb_target)
  );

  fetch_sequencer fetch_sequencer_i (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_redirect    (w_redirect),
    .i_redirect_pc (w_redirect_pc),
    .o_lookup_pc   (w_lookup_pc),
    .i_btb_hit     (w_btb_hit),
    .i_btb_target  (w_btb_target),
    .o_wb_cyc      (o_wb_cyc),
    .o_wb_stb      (o_wb_stb),
    .o_wb_adr      (o_wb_adr),
    .i_wb_dat      (i_wb_dat),
    .i_wb_ack      (i_wb_ack),
    .o_inst_valid  (o_inst_valid),
    .o_inst_pc     (o_inst_pc),
    .o_inst_data   (o_inst_data),
    .i_inst_ready  (i_inst_ready)
  );

endmodule

//--- hdl/trap_pkg.sv
// trap definitions: commit flush kinds and exception cause codes
package trap_pkg;

  localparam int CAUSE_W = 4;

  typedef logic [CAUSE_W-1:0] cause_t;

  // reason the committer flushed the pipeline
  typedef enum logic [2:0] {
    SILENT_FLUSH = 3'd0,  // resume after the flushing instruction
    REFETCH      = 3'd1,  // replay the flushing instruction
    MRET         = 3'd2,
    SRET         = 3'd3,
    EXCEPTION    = 3'd4   // trap through mtvec or stvec
  } flush_kind_t;

  // ==========================================================================
  // exception causes, standard mcause numbering
  // ==========================================================================
  localparam cause_t CAUSE_INST_MISALIGN    = 4'd0;
  localparam cause_t CAUSE_INST_ACCESS      = 4'd1;
  localparam cause_t CAUSE_ILLEGAL_INST     = 4'd2;
  localparam cause_t CAUSE_ECALL_U          = 4'd8;
  localparam cause_t CAUSE_ECALL_S          = 4'd9;
  localparam cause_t CAUSE_ECALL_M          = 4'd11;
  localparam cause_t CAUSE_INST_PAGE_FAULT  = 4'd12;
  localparam cause_t CAUSE_LOAD_PAGE_FAULT  = 4'd13;
  localparam cause_t CAUSE_STORE_PAGE_FAULT = 4'd15;

endpackage

//--- hdl/trap_target_calc.sv
// redirect target selection for committed flushes, traps and mispredicts
`timescale 1ns/10ps

module trap_target_calc
  import fetch_cfg_pkg::*;
  import trap_pkg::*;
(
  input  logic        i_cmt_valid,
  input  flush_kind_t i_cmt_kind,
  input  cause_t      i_cmt_cause,
  input  addr_t       i_cmt_epc,
  input  addr_t       i_mtvec,
  input  addr_t       i_stvec,
  input  addr_t       i_mepc,
  input  addr_t       i_sepc,
  input  logic [15:0] i_medeleg,
  input  logic        i_br_mispredict,
  input  addr_t       i_br_target,
  output logic        o_redirect,
  output addr_t       o_redirect_pc
);

  addr_t w_trap_vec;

  // delegated causes go to supervisor mode
  assign w_trap_vec = i_medeleg[i_cmt_cause] ? i_stvec : i_mtvec;

  assign o_redirect = i_cmt_valid | i_br_mispredict;

  always_comb begin
    o_redirect_pc = i_br_target;                  // mispredict unless commit wins
    if (i_cmt_valid) begin
      case (i_cmt_kind)
        SILENT_FLUSH : o_redirect_pc = i_cmt_epc + addr_t'(INST_BYTES);
        REFETCH      : o_redirect_pc = i_cmt_epc;
        MRET         : o_redirect_pc = i_mepc;
        SRET         : o_redirect_pc = i_sepc;
        EXCEPTION    : o_redirect_pc = {w_trap_vec[XLEN-1:2], 2'b00};  // mode bits dropped
        default      : o_redirect_pc = i_cmt_epc;
      endcase
    end
  end

endmodule

//--- verification/tb_fetch_unit.sv
// testbench for the fetch unit with a pc reference model and bus and decode protocol checks
`timescale 1ns/10ps

module tb_fetch_unit
  import fetch_cfg_pkg::*;
  import trap_pkg::*;
();

  localparam int unsigned SEED    = 32'hb60e_99c0;
  localparam int          TIMEOUT = 200;
  localparam int          RDY_RANDOM = 0;
  localparam int          RDY_LOW    = 1;
  localparam int          W_FULL  = 0;     // output full with the bus idle
  localparam int          W_BUS   = 1;     // bus cycle that continues past this edge

  logic        i_clk;
  logic        i_reset_n;
  logic        i_cmt_valid;
  flush_kind_t i_cmt_kind;
  cause_t      i_cmt_cause;
  addr_t       i_cmt_epc;
  addr_t       i_mtvec;
  addr_t       i_stvec;
  addr_t       i_mepc;
  addr_t       i_sepc;
  logic [15:0] i_medeleg;
  logic        i_br_upd_valid;
  addr_t       i_br_upd_pc;
  addr_t       i_br_upd_target;
  logic        i_br_upd_taken;
  logic        i_br_upd_mispredict;
  logic        o_wb_cyc;
  logic        o_wb_stb;
  addr_t       o_wb_adr;
  logic        o_wb_we;
  inst_t       i_wb_dat;
  logic        i_wb_ack;
  logic        o_inst_valid;
  addr_t       o_inst_pc;
  inst_t       o_inst_data;
  logic        i_inst_ready;

  int    ready_mode;
  int    errors;
  int    errors_at_start;
  int    n_pass;
  int    n_fail;
  logic  redir_now;
  addr_t redir_exp;       // target the pending redirect must land on
  addr_t exp_pc;          // pc of the next instruction decode should accept
  addr_t prev_inst_pc;
  inst_t prev_inst_data;
  addr_t prev_wb_adr;

  // reference btb direct mapped on the word index
  logic [BTB_ENTRIES-1:0] m_valid;
  addr_t                  m_pc  [BTB_ENTRIES];
  addr_t                  m_tgt [BTB_ENTRIES];
  logic [BTB_IDX_W-1:0]   upd_idx;

  fetch_unit fetch_unit_i (.*);

  wb_inst_mem wb_inst_mem_i (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_wb_cyc  (o_wb_cyc),
    .i_wb_stb  (o_wb_stb),
    .i_wb_adr  (o_wb_adr),
    .i_wb_we   (o_wb_we),
    .o_wb_dat  (i_wb_dat),
    .o_wb_ack  (i_wb_ack)
  );

  always #2 i_clk = ~i_clk;

  assign redir_now = i_cmt_valid | (i_br_upd_valid & i_br_upd_mispredict);
  assign upd_idx   = i_br_upd_pc[2 +: BTB_IDX_W];

  always @(posedge i_clk) begin
    if (ready_mode == RDY_LOW) begin
      i_inst_ready <= 1'b0;
    end else begin
      i_inst_ready <= 1'($urandom_range(1, 0));
    end
  end

  // ==========================================================================
  // reference model
  // ==========================================================================
  function automatic addr_t model_next(input addr_t pc);
    logic [BTB_IDX_W-1:0] idx;
    idx = pc[2 +: BTB_IDX_W];
    if (m_valid[idx] && m_pc[idx] == pc) begin
      return m_tgt[idx];
    end
    return pc + 32'd4;
  endfunction

  always @(posedge i_clk) begin
    prev_inst_pc   <= o_inst_pc;
    prev_inst_data <= o_inst_data;
    prev_wb_adr    <= o_wb_adr;
    if (i_reset_n) begin
      if (redir_now) begin
        exp_pc <= redir_exp;                      // output and in-flight data dropped
      end else if (o_inst_valid && i_inst_ready) begin
        exp_pc <= model_next(exp_pc);
      end
      if (i_br_upd_valid && i_br_upd_taken) begin
        m_valid[upd_idx] <= 1'b1;
        m_pc[upd_idx]    <= i_br_upd_pc;
        m_tgt[upd_idx]   <= i_br_upd_target;
      end else if (i_br_upd_valid && m_valid[upd_idx] && m_pc[upd_idx] == i_br_upd_pc) begin
        m_valid[upd_idx] <= 1'b0;
      end
    end
  end

  // ==========================================================================
  // checks
  // ==========================================================================
  a_inst_pc : assert property (@(posedge i_clk) disable iff (!i_reset_n)
      (o_inst_valid && i_inst_ready && !redir_now) |-> (o_inst_pc == exp_pc))
    else begin
      errors++;
      $display("Fail t=%0t o_inst_pc: got %h expected %h", $time,
               $sampled(o_inst_pc), $sampled(exp_pc));
    end

  a_inst_data : assert property (@(posedge i_clk) disable iff (!i_reset_n)
      (o_inst_valid && i_inst_ready) |-> (o_inst_data == ~o_inst_pc))
    else begin
      errors++;
      $display("Fail t=%0t o_inst_data: got %h expected %h", $time,
               $sampled(o_inst_data), ~$sampled(o_inst_pc));
    end

  // stalled output holds until taken
  a_inst_hold : assert property (@(posedge i_clk) disable iff (!i_reset_n)
      (o_inst_valid && !i_inst_ready && !redir_now) |=>
      (o_inst_valid && o_inst_pc == prev_inst_pc && o_inst_data == prev_inst_data))
    else begin
      errors++;
      $display("Fail t=%0t o_inst_valid/pc/data: got %b/%h/%h expected 1/%h/%h", $time,
               $sampled(o_inst_valid), $sampled(o_inst_pc), $sampled(o_inst_data),
               $sampled(prev_inst_pc), $sampled(prev_inst_data));
    end

  a_no_fetch_full : assert property (@(posedge i_clk) disable iff (!i_reset_n)
      (o_inst_valid && !i_inst_ready && !o_wb_cyc && !redir_now) |=> !o_wb_stb)
    else begin
      errors++;
      $display("Fail t=%0t o_wb_stb: got 1 expected 0", $time);
    end

  a_bus_hold : assert property (@(posedge i_clk) disable iff (!i_reset_n)
      (o_wb_stb && !i_wb_ack) |=> (o_wb_stb && o_wb_adr == prev_wb_adr))
    else begin
      errors++;
      $display("Fail t=%0t o_wb_stb/o_wb_adr: got %b/%h expected 1/%h", $time,
               $sampled(o_wb_stb), $sampled(o_wb_adr), $sampled(prev_wb_adr));
    end

  // cyc and stb frame each bus cycle together
  a_cyc_stb : assert property (@(posedge i_clk) disable iff (!i_reset_n)
      o_wb_cyc == o_wb_stb)
    else begin
      errors++;
      $display("Fail t=%0t o_wb_cyc: got %b expected %b", $time,
               $sampled(o_wb_cyc), $sampled(o_wb_stb));
    end

  a_we_low : assert property (@(posedge i_clk) disable iff (!i_reset_n) !o_wb_we)
    else begin
      errors++;
      $display("Fail t=%0t o_wb_we: got 1 expected 0", $time);
    end

  // ==========================================================================
  // stimulus tasks
  // ==========================================================================
  task automatic wait_transfers(input int count);
    int seen;
    int cycles;
    seen   = 0;
    cycles = 0;
    while (seen < count && cycles < TIMEOUT) begin
      @(posedge i_clk);
      cycles++;
      if (o_inst_valid && i_inst_ready && !redir_now) begin
        seen++;
      end
    end
    if (seen < count) begin
      errors++;
      $display("timeout at %0t: only %0d of %0d instructions reached decode",
               $time, seen, count);
    end
  endtask

  task automatic wait_for(input int what, input string desc);
    int  cycles;
    logic met;
    cycles = 0;
    met    = 1'b0;
    while (!met && cycles < TIMEOUT) begin
      @(posedge i_clk);
      cycles++;
      met = (what == W_FULL) ? (o_inst_valid && !o_wb_cyc) : (o_wb_cyc && !i_wb_ack);
    end
    if (!met) begin
      errors++;
      $display("timeout at %0t: never saw %s", $time, desc);
    end
  endtask

  // one-cycle mispredict pulse after which fetch resumes at the target
  task automatic resolve_branch(input addr_t pc, input addr_t target, input logic taken);
    i_br_upd_valid      <= 1'b1;
    i_br_upd_mispredict <= 1'b1;
    i_br_upd_pc         <= pc;
    i_br_upd_target     <= target;
    i_br_upd_taken      <= taken;
    redir_exp           <= target;
    @(posedge i_clk);
    i_br_upd_valid      <= 1'b0;
    i_br_upd_mispredict <= 1'b0;
  endtask

  task automatic commit_flush(input flush_kind_t kind, input cause_t cause, input addr_t epc,
                              input addr_t expect_pc, input logic with_br);
    i_cmt_valid         <= 1'b1;
    i_cmt_kind          <= kind;
    i_cmt_cause         <= cause;
    i_cmt_epc           <= epc;
    i_br_upd_valid      <= with_br;             // competing mispredict that loses
    i_br_upd_mispredict <= with_br;
    i_br_upd_pc         <= 32'h0000_7000;
    i_br_upd_target     <= 32'h0000_6000;
    i_br_upd_taken      <= 1'b0;
    redir_exp           <= expect_pc;
    @(posedge i_clk);
    i_cmt_valid         <= 1'b0;
    i_br_upd_valid      <= 1'b0;
    i_br_upd_mispredict <= 1'b0;
  endtask

  task automatic end_test(input string name);
    if (errors == errors_at_start) begin
      n_pass++;
      $display("test %-28s pass", name);
    end else begin
      n_fail++;
      $display("test %-28s fail, %0d errors", name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  // ==========================================================================
  // test sequence
  // ==========================================================================
  initial begin
    void'($urandom(SEED));
    i_clk = 1'b0;
    i_reset_n = 1'b0;
    i_cmt_valid = 1'b0;
    i_cmt_kind = SILENT_FLUSH;
    i_cmt_cause = '0;
    i_cmt_epc = '0;
    i_mtvec = 32'h0000_4003;
    i_stvec = 32'h0000_5001;
    i_mepc = 32'h0000_3000;
    i_sepc = 32'h0000_3400;
    i_medeleg = 16'h0000;
    i_br_upd_valid = 1'b0;
    i_br_upd_pc = '0;
    i_br_upd_target = '0;
    i_br_upd_taken = 1'b0;
    i_br_upd_mispredict = 1'b0;
    i_inst_ready = 1'b0;
    ready_mode = RDY_RANDOM;
    errors = 0;
    errors_at_start = 0;
    n_pass = 0;
    n_fail = 0;
    redir_exp = RESET_PC;
    exp_pc = RESET_PC;
    m_valid = '0;
    repeat (5) @(posedge i_clk);
    i_reset_n <= 1'b1;

    wait_transfers(8);
    end_test("sequential fetch");

    ready_mode <= RDY_LOW;
    wait_for(W_FULL, "a full output with the bus idle");
    repeat (12) @(posedge i_clk);
    end_test("back-pressure");

    resolve_branch(32'h0000_1f00, 32'h0000_1a00, 1'b0);     // bus idle here
    ready_mode <= RDY_RANDOM;
    wait_transfers(3);
    end_test("mispredict outside bus");

    wait_for(W_BUS, "a bus cycle in progress");
    resolve_branch(32'h0000_1f40, 32'h0000_1c00, 1'b0);
    wait_transfers(3);
    end_test("mispredict inside bus");

    wait_transfers(20);
    end_test("bus protocol");

    // train 1200 -> 1340 and evict it again
    resolve_branch(32'h0000_1200, 32'h0000_1340, 1'b1);
    wait_transfers(2);
    commit_flush(REFETCH, '0, 32'h0000_1200, 32'h0000_1200, 1'b0);
    wait_transfers(3);
    resolve_branch(32'h0000_1200, 32'h0000_1204, 1'b0);
    wait_transfers(2);
    commit_flush(REFETCH, '0, 32'h0000_1200, 32'h0000_1200, 1'b0);
    wait_transfers(3);
    end_test("btb train and clear");

    commit_flush(SILENT_FLUSH, '0, 32'h0000_2000, 32'h0000_2004, 1'b0);
    wait_transfers(2);
    commit_flush(REFETCH, '0, 32'h0000_2100, 32'h0000_2100, 1'b0);
    wait_transfers(2);
    commit_flush(MRET, '0, 32'h0000_2180, 32'h0000_3000, 1'b0);
    wait_transfers(2);
    commit_flush(SRET, '0, 32'h0000_2180, 32'h0000_3400, 1'b0);
    wait_transfers(2);
    i_medeleg <= 16'h0004;                     // illegal instruction delegated
    commit_flush(EXCEPTION, CAUSE_ILLEGAL_INST, 32'h0000_2180, 32'h0000_5000, 1'b0);
    wait_transfers(2);
    i_medeleg <= 16'h0000;
    commit_flush(EXCEPTION, CAUSE_ILLEGAL_INST, 32'h0000_2180, 32'h0000_4000, 1'b0);
    wait_transfers(2);
    commit_flush(REFETCH, '0, 32'h0000_2200, 32'h0000_2200, 1'b1);
    wait_transfers(2);
    end_test("commit flush targets");

    $display("tests run %0d: %0d passed, %0d failed, %0d check failures",
             n_pass + n_fail, n_pass, n_fail, errors);
    if (n_fail == 0 && errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- verification/wb_inst_mem.sv
// wishbone classic instruction memory model, inverted-address data and random ack delay
`timescale 1ns/10ps

module wb_inst_mem
  import fetch_cfg_pkg::*;
(
  input  logic  i_clk,
  input  logic  i_reset_n,
  input  logic  i_wb_cyc,
  input  logic  i_wb_stb,
  input  addr_t i_wb_adr,
  input  logic  i_wb_we,
  output inst_t o_wb_dat,
  output logic  o_wb_ack
);

  logic       r_busy;
  logic [1:0] r_wait;     // wait states left before ack

  // every word reads back as its inverted address
  assign o_wb_dat = ~i_wb_adr;

  always @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_wb_ack <= 1'b0;
      r_busy   <= 1'b0;
      r_wait   <= 2'd0;
    end else if (o_wb_ack) begin
      o_wb_ack <= 1'b0;                   // single-cycle ack
      r_busy   <= 1'b0;
    end else if (r_busy) begin
      if (r_wait == 2'd0) begin
        o_wb_ack <= 1'b1;
      end else begin
        r_wait <= r_wait - 2'd1;
      end
    end else if (i_wb_cyc && i_wb_stb && !i_wb_we) begin
      r_busy <= 1'b1;
      r_wait <= 2'($urandom_range(3, 0));
    end
  end

endmodule

//--- vlog.f
hdl/fetch_cfg_pkg.sv
hdl/trap_pkg.sv
hdl/btb_update_if.sv
hdl/trap_target_calc.sv
hdl/btb.sv
hdl/fetch_sequencer.sv
hdl/fetch_unit.sv
verification/wb_inst_mem.sv
verification/tb_fetch_unit.sv
